// File: vga_console.f
+incdir+.
console_pkg.sv
vga_timing.sv
char_rom.sv
host_regs.sv
glyph_renderer.sv
vga_console.sv
tb_vga_console.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the console testbench with Verilator, pass only on the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv --timescale 1ns/1ps \
    -f vga_console.f --top-module tb_vga_console \
    -Mdir obj_dir -o sim_vga_console
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_vga_console > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: tb_vga_console.sv
// Testbench for vga_console with bus tasks, displayed-pixel tracker, colour model and assertions
`timescale 1ns/1ps
`default_nettype none

`include "console_consts.svh"

module tb_vga_console
    import console_pkg::*;
();

    localparam int HS_START       = `H_VISIBLE + `H_FRONT;  // First hsync pixel
    localparam int VS_START       = `V_VISIBLE + `V_FRONT;  // First vsync line
    localparam int TIMEOUT_CYCLES = 3 * `H_TOTAL * `V_TOTAL + 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [7:0]  uo_out;
    reg_addr_t   address;
    logic [31:0] data_in;
    logic [1:0]  data_write_n;
    logic [1:0]  data_read_n;
    logic [31:0] data_out;
    logic        data_ready;
    logic        user_interrupt;

    // Reference picture state, changed only while checking is off
    logic   check_on;
    logic   model_solid;                 // Buffer holds 0x7F, else 0x20
    logic   model_transp;
    color_t model_tc, model_bc;

    // Tracker of the pixel on uo_out, updated on the falling edge
    int     tx, ty;
    logic   x_valid, pos_valid;
    logic   prev_hs, prev_vs, prev_irq;
    logic   hs_fell, hs_rose, vs_fell;
    logic   h_seen, v_seen;
    int     h_gap, h_low, v_gap;
    logic   chk_hperiod, chk_hlow, chk_vperiod;
    int     got_hperiod, got_hlow, got_vperiod;
    logic   irq_rose, irq_rose_last, irq_fell, irq_now;
    logic   rd_now, rd_last;         // Host status read seen this and last cycle
    logic   chk_pix, chk_blank;
    color_t exp_pix, got_pix;
    int     pix_checks = 0;
    int     cycle_count = 0;
    logic [31:0] rng;

    vga_console u_vga_console (
        .clk            (clk),
        .rst_n          (rst_n),
        .ui_in          (ui_in),
        .uo_out         (uo_out),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_read_n    (data_read_n),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .user_interrupt (user_interrupt)
    );

    always #10 clk = ~clk;  // 50 MHz stand-in for the pixel clock

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic mismatch(input string name, input logic [31:0] expv, input logic [31:0] actv);
        abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h", name, expv, actv));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic logic is_blank(input int x, input int y);
        return (x >= `H_VISIBLE) || (y >= `V_VISIBLE);
    endfunction

    // {hsync, B0, G0, R0, vsync, B1, G1, R1} back to {B, G, R}
    function automatic color_t pmod_color(input logic [7:0] uo);
        return {uo[2], uo[6], uo[1], uo[5], uo[0], uo[4]};
    endfunction

    function automatic color_t expected_color(input int x, input int y);
        int   rx, ry;
        logic on;
        if (is_blank(x, y)) return '0;
        on = 1'b0;
        if (x >= `FRAME_XMIN && x < `FRAME_XMAX && y >= `FRAME_YMIN && y < `FRAME_YMAX) begin
            rx = ((x - `FRAME_XMIN) % `CELL_W) / `GLYPH_SCALE;
            ry = ((y - `FRAME_YMIN) % `CELL_H) / `GLYPH_SCALE;
            on = model_solid && (rx < 5) && (ry < 7);   // Column 5 and row 7 are padding
        end
        if (on) return model_transp ? (model_tc | model_bc) : model_tc;
        return model_bc;
    endfunction

    task automatic write_reg(input reg_addr_t a, input logic [31:0] d);
        @(posedge clk);
        address      <= a;
        data_in      <= d;
        data_write_n <= 2'b00;
        @(posedge clk);                  // Write lands on this edge
        data_write_n <= 2'b11;
    endtask

    task automatic read_reg(input reg_addr_t a, output logic [31:0] d);
        @(posedge clk);
        address     <= a;
        data_read_n <= 2'b00;
        @(negedge clk);
        d = data_out;                    // Combinational read, stable mid-cycle
        @(posedge clk);
        data_read_n <= 2'b11;
    endtask

    task automatic check_read(input reg_addr_t a, input logic [31:0] expv, input string name);
        logic [31:0] d;
        read_reg(a, d);
        assert (d == expv) else mismatch(name, expv, d);
    endtask

    // Status bits follow the DUT counters, one pixel ahead of uo_out
    task automatic check_status();
        logic [31:0] d;
        int          nx, ny;
        read_reg(`REG_VGA, d);
        nx = (tx == `H_TOTAL - 1) ? 0 : tx + 1;
        ny = ty;
        if (nx == 0) ny = (ty == `V_TOTAL - 1) ? 0 : ty + 1;
        assert (d == {30'd0, (ny < VS_START) || (ny >= VS_START + `V_SYNC), is_blank(nx, ny)})
            else mismatch("REG_VGA status", {30'd0, (ny < VS_START) || (ny >= VS_START + `V_SYNC),
                                             is_blank(nx, ny)}, d);
    endtask

    task automatic fill_buffer(input char_code_t code);
        check_on = 1'b0;
        for (int i = 0; i < `NUM_CHARS; i++) write_reg(reg_addr_t'(i), {25'd0, code});
        model_solid = (code == 7'h7F);
    endtask

    task automatic set_colors(input color_t tc, input color_t bc, input logic tr);
        check_on = 1'b0;
        write_reg(`REG_TEXT_COLOR, {24'd0, tr, 1'b0, tc});
        write_reg(`REG_BG_COLOR, {26'd0, bc});
        model_tc     = tc;
        model_bc     = bc;
        model_transp = tr;
    endtask

    task automatic resume_checks();
        repeat (2) @(posedge clk);       // New values reach the output register
        check_on = 1'b1;
    endtask

    task automatic wait_pos(input int x, input int y);
        @(posedge clk);
        while (!(pos_valid && tx == x && ty == y)) @(posedge clk);
    endtask

    // Frame flag must hold until the host reads REG_VGA
    task automatic serve_frame_irq();
        @(negedge clk);
        while (!user_interrupt) @(negedge clk);
        repeat (2 * `H_TOTAL) @(negedge clk);
        assert (user_interrupt) else mismatch("irq held", 32'd1, 32'd0);
        check_status();
        @(negedge clk);
        assert (!user_interrupt) else mismatch("irq cleared", 32'd0, 32'd1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) abort_run("Timeout: the run went past its cycle limit");
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            prev_hs = 1'b1;
            prev_vs = 1'b1;
            prev_irq = 1'b0;
            {x_valid, pos_valid, h_seen, v_seen} = '0;
            {chk_hperiod, chk_hlow, chk_vperiod, chk_pix, chk_blank} = '0;
            {irq_rose, irq_rose_last, irq_fell, rd_now, rd_last} = '0;
            tx = 0;
            ty = 0;
        end else begin
            hs_fell = prev_hs && !uo_out[7];
            hs_rose = !prev_hs && uo_out[7];
            vs_fell = prev_vs && !uo_out[3];
            if (hs_fell) begin
                tx = HS_START;           // Registered sync shows with its own pixel
                x_valid = 1'b1;
            end else if (tx == `H_TOTAL - 1) begin
                tx = 0;
                ty = (ty == `V_TOTAL - 1) ? 0 : ty + 1;
            end else begin
                tx = tx + 1;
            end
            if (vs_fell) begin
                ty = VS_START;
                pos_valid = x_valid;
            end
            h_gap = h_gap + 1;
            v_gap = v_gap + 1;
            chk_hperiod = hs_fell && h_seen;
            got_hperiod = h_gap;
            if (hs_fell) begin
                h_gap = 0;
                h_low = 0;
                h_seen = 1'b1;
            end
            if (!uo_out[7]) h_low = h_low + 1;
            chk_hlow = hs_rose && h_seen;
            got_hlow = h_low;
            chk_vperiod = vs_fell && v_seen;
            got_vperiod = v_gap;
            if (vs_fell) begin
                v_gap = 0;
                v_seen = 1'b1;
            end
            irq_rose_last = irq_rose;
            irq_rose = !prev_irq && user_interrupt;
            irq_fell = prev_irq && !user_interrupt;
            irq_now = user_interrupt;
            rd_last = rd_now;
            rd_now = (data_read_n != 2'b11) && (address == `REG_VGA);
            exp_pix = expected_color(tx, ty);
            got_pix = pmod_color(uo_out);
            chk_pix = pos_valid && check_on;
            chk_blank = pos_valid && is_blank(tx, ty);
            if (chk_pix) pix_checks = pix_checks + 1;
            prev_hs = uo_out[7];
            prev_vs = uo_out[3];
            prev_irq = user_interrupt;
        end
    end

    a_ready: assert property (@(posedge clk) data_ready == 1'b1)
        else mismatch("data_ready", 32'd1, {31'd0, data_ready});
    a_h_period: assert property (@(posedge clk) disable iff (!rst_n)
        chk_hperiod |-> got_hperiod == `H_TOTAL) else mismatch("hsync period", `H_TOTAL, got_hperiod);
    a_h_low: assert property (@(posedge clk) disable iff (!rst_n)
        chk_hlow |-> got_hlow == `H_SYNC) else mismatch("hsync width", `H_SYNC, got_hlow);
    a_v_period: assert property (@(posedge clk) disable iff (!rst_n)
        chk_vperiod |-> got_vperiod == `H_TOTAL * `V_TOTAL)
        else mismatch("vsync period", `H_TOTAL * `V_TOTAL, got_vperiod);
    a_pixel: assert property (@(posedge clk) disable iff (!rst_n) chk_pix |-> got_pix == exp_pix)
        else mismatch($sformatf("pixel at %0d,%0d", tx, ty), 32'(exp_pix), 32'(got_pix));
    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n) chk_blank |-> got_pix == '0)
        else mismatch($sformatf("blank pixel at %0d,%0d", tx, ty), 32'd0, 32'(got_pix));
    a_irq_with_vsync: assert property (@(posedge clk) disable iff (!rst_n) vs_fell |-> irq_rose_last)
        else abort_run("user_interrupt did not rise together with the vsync falling edge");
    a_irq_rise_pos: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_rose && pos_valid) |-> (tx == `H_TOTAL - 1 && ty == VS_START - 1))
        else abort_run("user_interrupt rose away from the start of vsync");
    a_irq_hold: assert property (@(posedge clk) disable iff (!rst_n) irq_fell |-> rd_last)
        else abort_run("user_interrupt fell without a read of REG_VGA");
    a_irq_clear: assert property (@(posedge clk) disable iff (!rst_n) rd_last |-> !irq_now)
        else abort_run("user_interrupt still high the cycle after a read of REG_VGA");

    initial begin
        logic [31:0] r, expv;
        color_t      tc, bc;
        char_code_t  shadow [`NUM_CHARS];
        rst_n = 1'b0;
        ui_in = 8'h00;
        address = '0;
        data_in = '0;
        data_write_n = 2'b11;
        data_read_n = 2'b11;
        check_on = 1'b0;
        model_solid = 1'b0;
        model_transp = 1'b0;
        model_tc = '0;
        model_bc = '0;
        rng = 32'h5825;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Reset values
        assert (user_interrupt == 1'b0) else mismatch("irq after reset", 32'd0, 32'd1);
        check_read(`REG_TEXT_COLOR, 32'd12, "text colour reset");
        check_read(`REG_BG_COLOR, 32'd16, "background reset");
        // Random writes, masked readback over the whole map
        for (int i = 0; i < `NUM_CHARS; i++) begin
            rng = xorshift(rng);
            write_reg(reg_addr_t'(i), rng);
            shadow[i] = rng[6:0];
        end
        rng = xorshift(rng);
        write_reg(`REG_TEXT_COLOR, rng);
        r = {24'd0, rng[7], 1'b0, rng[5:0]};
        rng = xorshift(rng);
        write_reg(`REG_BG_COLOR, rng);
        for (int a = 0; a < 64; a++) begin
            if (a < `NUM_CHARS) expv = {25'd0, shadow[a]};
            else if (a == `REG_TEXT_COLOR) expv = r;
            else if (a == `REG_BG_COLOR) expv = {26'd0, rng[5:0]};
            else expv = '0;
            if (a != `REG_VGA) check_read(reg_addr_t'(a), expv, $sformatf("readback 0x%0h", a));
        end
        // Picture, row 0 solid, row 1 transparent, row 2 onward spaces
        rng = xorshift(rng);
        tc = rng[5:0];
        bc = rng[13:8];
        if (tc == 6'h3F) tc = 6'h0C;
        if ((tc | bc) == tc) bc = ~tc;   // Transparent mix must differ from text
        fill_buffer(7'h7F);
        set_colors(tc, bc, 1'b0);
        resume_checks();
        serve_frame_irq();
        wait_pos(0, 250);
        set_colors(tc, bc, 1'b1);
        resume_checks();
        wait_pos(0, 380);
        fill_buffer(7'h20);
        resume_checks();
        wait_pos(100, 600);
        check_status();                  // Visible
        wait_pos(1100, 600);
        check_status();                  // Horizontal blank
        serve_frame_irq();
        wait_pos(0, 400);
        if (pix_checks == 0) begin
            abort_run("No pixel of the picture was checked");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule : tb_vga_console

`default_nettype wire

// File: vga_console.sv
// Text console peripheral top with timing, registers, glyph ROM and renderer
`timescale 1ns/1ps
`default_nettype none

module vga_console
    import console_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  ui_in,          // PMOD input, not used here
    output logic [7:0]  uo_out,         // TinyVGA PMOD
    input  reg_addr_t   address,
    input  logic [31:0] data_in,
    input  logic [1:0]  data_write_n,
    input  logic [1:0]  data_read_n,
    output logic [31:0] data_out,
    output logic        data_ready,
    output logic        user_interrupt
);

    pix_coord_t pix_x, pix_y;
    logic       hsync, vsync, blank;
    logic       frame_irq;
    logic       read_status_strobe;
    buf_addr_t  buf_addr;
    char_code_t buf_char, glyph_code;
    glyph_t     glyph_bits;
    color_t     text_color, bg_color;
    logic       transparent;

    vga_timing u_vga_timing (
        .clk                (clk),
        .rst_n              (rst_n),
        .read_status_strobe (read_status_strobe),
        .pix_x              (pix_x),
        .pix_y              (pix_y),
        .hsync              (hsync),
        .vsync              (vsync),
        .blank              (blank),
        .frame_irq          (frame_irq)
    );

    host_regs u_host_regs (
        .clk                (clk),
        .rst_n              (rst_n),
        .address            (address),
        .data_in            (data_in),
        .data_write_n       (data_write_n),
        .data_read_n        (data_read_n),
        .data_out           (data_out),
        .vsync              (vsync),
        .blank              (blank),
        .buf_addr           (buf_addr),
        .buf_char           (buf_char),
        .text_color         (text_color),
        .bg_color           (bg_color),
        .transparent        (transparent),
        .read_status_strobe (read_status_strobe)
    );

    char_rom u_char_rom (
        .glyph_code (glyph_code),
        .glyph_bits (glyph_bits)
    );

    glyph_renderer u_glyph_renderer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .hsync       (hsync),
        .vsync       (vsync),
        .blank       (blank),
        .buf_addr    (buf_addr),
        .buf_char    (buf_char),
        .glyph_code  (glyph_code),
        .glyph_bits  (glyph_bits),
        .text_color  (text_color),
        .bg_color    (bg_color),
        .transparent (transparent),
        .uo_out      (uo_out)
    );

    assign data_ready     = 1'b1;       // Every access completes at once
    assign user_interrupt = frame_irq;

endmodule : vga_console

`default_nettype wire

// File: glyph_renderer.sv
// Text window test, cell addressing, glyph pixel pick and registered PMOD output
`timescale 1ns/1ps
`default_nettype none

`include "console_consts.svh"

module glyph_renderer
    import console_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pix_coord_t pix_x,
    input  pix_coord_t pix_y,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       blank,
    output buf_addr_t  buf_addr,
    input  char_code_t buf_char,
    output char_code_t glyph_code,
    input  glyph_t     glyph_bits,
    input  color_t     text_color,
    input  color_t     bg_color,
    input  logic       transparent,
    output logic [7:0] uo_out          // TinyVGA PMOD
);

    logic       x_in, y_in, frame_active;
    logic [6:0] cell_px;     // Pixel within the current cell, 0 to CELL_W-1
    logic [3:0] char_x;      // Cell column, runs past 9 outside the window
    logic [1:0] char_y;
    buf_addr_t  cell_addr;
    logic [2:0] rel_x, rel_y;
    logic [5:0] offset;
    logic       padding, glyph_on;
    color_t     color_q;
    logic       hsync_q, vsync_q;

    assign x_in = (pix_x >= pix_coord_t'(`FRAME_XMIN)) && (pix_x < pix_coord_t'(`FRAME_XMAX));
    assign y_in = (pix_y >= pix_coord_t'(`FRAME_YMIN)) && (pix_y < pix_coord_t'(`FRAME_YMAX));
    assign frame_active = x_in && y_in;

    // Running cell counter avoids a divide by 96
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cell_px <= '0;
            char_x  <= '0;
        end else if (pix_x == pix_coord_t'(`FRAME_XMIN - 1)) begin
            cell_px <= '0;                   // Column 0 starts on the next pixel
            char_x  <= '0;
        end else if (cell_px == 7'(`CELL_W - 1)) begin
            cell_px <= '0;
            char_x  <= char_x + 4'd1;
        end else begin
            cell_px <= cell_px + 7'd1;
        end
    end

    // Rows are 128 lines, so the row is pix_y[8:7] minus the top margin row
    assign char_y = pix_y[8:7] - 2'd1;

    // row*10 + col as shift-add
    assign cell_addr = ({3'd0, char_y} << 3) + ({3'd0, char_y} << 1) + {1'b0, char_x};
    assign buf_addr  = (cell_addr < buf_addr_t'(`NUM_CHARS)) ? cell_addr : '0;
    assign glyph_code = buf_char;

    // Glyph pixels are 16x16 screen pixels
    assign rel_x   = cell_px[6:4];
    assign rel_y   = pix_y[6:4];
    assign padding = (rel_x == 3'd5) || (rel_y == 3'd7);  // Right column, bottom row
    assign offset  = ({3'd0, rel_y} << 2) + {3'd0, rel_y} + {3'd0, rel_x};
    assign glyph_on = !padding && glyph_bits[padding ? 6'd0 : offset];

    // One register stage keeps syncs aligned with colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
            color_q <= '0;
        end else begin
            hsync_q <= hsync;
            vsync_q <= vsync;
            if (blank) begin
                color_q <= '0;                                  // Black in porches
            end else if (frame_active && glyph_on) begin
                color_q <= transparent ? (text_color | bg_color) : text_color;
            end else begin
                color_q <= bg_color;
            end
        end
    end

    // {hsync, B0, G0, R0, vsync, B1, G1, R1}
    assign uo_out = {hsync_q, color_q[4], color_q[2], color_q[0],
                     vsync_q, color_q[5], color_q[3], color_q[1]};

endmodule : glyph_renderer

`default_nettype wire

// File: host_regs.sv
// Bus decode, text buffer, colour registers, read mux and status read strobe
`timescale 1ns/1ps
`default_nettype none

`include "console_consts.svh"

module host_regs
    import console_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  reg_addr_t   address,
    input  logic [31:0] data_in,        // Only bits 7:0 are used
    input  logic [1:0]  data_write_n,   // 2'b11 means idle
    input  logic [1:0]  data_read_n,    // 2'b11 means idle
    output logic [31:0] data_out,
    input  logic        vsync,
    input  logic        blank,
    input  buf_addr_t   buf_addr,       // Renderer read port
    output char_code_t  buf_char,
    output color_t      text_color,
    output color_t      bg_color,
    output logic        transparent,
    output logic        read_status_strobe
);

    char_code_t text_buf [`NUM_CHARS];  // One code per cell

    logic      wr_en;
    logic      buf_sel;    // Address falls in the text buffer
    buf_addr_t host_idx;

    assign wr_en    = (data_write_n != 2'b11);
    assign buf_sel  = (address < reg_addr_t'(`NUM_CHARS));
    assign host_idx = buf_addr_t'(address);

    // Text buffer write
    always_ff @(posedge clk) begin
        if (wr_en && buf_sel) begin
            text_buf[host_idx] <= data_in[6:0];
        end
    end

    // Colour and transparency registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            text_color  <= `RESET_TEXT_COLOR;
            bg_color    <= `RESET_BG_COLOR;
            transparent <= 1'b0;
        end else if (wr_en) begin
            if (address == `REG_TEXT_COLOR) begin
                text_color  <= data_in[5:0];
                transparent <= data_in[7];
            end else if (address == `REG_BG_COLOR) begin
                bg_color <= data_in[5:0];
            end
        end
    end

    // Zero latency read mux
    always_comb begin
        data_out = '0;
        if (buf_sel) begin
            data_out = {25'd0, text_buf[host_idx]};
        end else if (address == `REG_TEXT_COLOR) begin
            data_out = {24'd0, transparent, 1'b0, text_color};
        end else if (address == `REG_BG_COLOR) begin
            data_out = {26'd0, bg_color};
        end else if (address == `REG_VGA) begin
            data_out = {30'd0, vsync, blank};  // Live status bits
        end
    end

    // Status read clears the frame interrupt
    assign read_status_strobe = (data_read_n != 2'b11) && (address == `REG_VGA);

    assign buf_char = text_buf[buf_addr];  // Second read port for the renderer

    // Renderer clamps its cell address
    a_rd_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        buf_addr < buf_addr_t'(`NUM_CHARS)
    ) else $error("Renderer read at or above NUM_CHARS");

endmodule : host_regs

`default_nettype wire

// File: char_rom.sv
// Combinational 5x7 glyph ROM for space, digits, capitals and a solid block
`timescale 1ns/1ps
`default_nettype none

module char_rom
    import console_pkg::*;
(
    input  char_code_t glyph_code,
    output glyph_t     glyph_bits
);

    // Art is written row 0 first, left pixel as the MSB of each row
    glyph_t art;

    always_comb begin
        case (glyph_code)
            7'h20: art = 35'b00000_00000_00000_00000_00000_00000_00000;  // Space
            7'h30: art = 35'b01110_10001_10011_10101_11001_10001_01110;  // 0
            7'h31: art = 35'b00100_01100_00100_00100_00100_00100_01110;  // 1
            7'h32: art = 35'b01110_10001_00001_00010_00100_01000_11111;  // 2
            7'h33: art = 35'b11111_00010_00100_00010_00001_10001_01110;  // 3
            7'h34: art = 35'b00010_00110_01010_10010_11111_00010_00010;  // 4
            7'h35: art = 35'b11111_10000_11110_00001_00001_10001_01110;  // 5
            7'h36: art = 35'b00110_01000_10000_11110_10001_10001_01110;  // 6
            7'h37: art = 35'b11111_00001_00010_00100_01000_01000_01000;  // 7
            7'h38: art = 35'b01110_10001_10001_01110_10001_10001_01110;  // 8
            7'h39: art = 35'b01110_10001_10001_01111_00001_00010_01100;  // 9
            7'h41: art = 35'b01110_10001_10001_11111_10001_10001_10001;  // A
            7'h42: art = 35'b11110_10001_10001_11110_10001_10001_11110;  // B
            7'h43: art = 35'b01110_10001_10000_10000_10000_10001_01110;  // C
            7'h44: art = 35'b11100_10010_10001_10001_10001_10010_11100;  // D
            7'h45: art = 35'b11111_10000_10000_11110_10000_10000_11111;  // E
            7'h46: art = 35'b11111_10000_10000_11110_10000_10000_10000;  // F
            7'h47: art = 35'b01110_10001_10000_10111_10001_10001_01111;  // G
            7'h48: art = 35'b10001_10001_10001_11111_10001_10001_10001;  // H
            7'h49: art = 35'b01110_00100_00100_00100_00100_00100_01110;  // I
            7'h4A: art = 35'b00111_00010_00010_00010_00010_10010_01100;  // J
            7'h4B: art = 35'b10001_10010_10100_11000_10100_10010_10001;  // K
            7'h4C: art = 35'b10000_10000_10000_10000_10000_10000_11111;  // L
            7'h4D: art = 35'b10001_11011_10101_10101_10001_10001_10001;  // M
            7'h4E: art = 35'b10001_10001_11001_10101_10011_10001_10001;  // N
            7'h4F: art = 35'b01110_10001_10001_10001_10001_10001_01110;  // O
            7'h50: art = 35'b11110_10001_10001_11110_10000_10000_10000;  // P
            7'h51: art = 35'b01110_10001_10001_10001_10101_10010_01101;  // Q
            7'h52: art = 35'b11110_10001_10001_11110_10100_10010_10001;  // R
            7'h53: art = 35'b01111_10000_10000_01110_00001_00001_11110;  // S
            7'h54: art = 35'b11111_00100_00100_00100_00100_00100_00100;  // T
            7'h55: art = 35'b10001_10001_10001_10001_10001_10001_01110;  // U
            7'h56: art = 35'b10001_10001_10001_10001_10001_01010_00100;  // V
            7'h57: art = 35'b10001_10001_10001_10101_10101_10101_01010;  // W
            7'h58: art = 35'b10001_10001_01010_00100_01010_10001_10001;  // X
            7'h59: art = 35'b10001_10001_10001_01010_00100_00100_00100;  // Y
            7'h5A: art = 35'b11111_00001_00010_00100_01000_10000_11111;  // Z
            7'h7F: art = '1;                                             // Solid block
            default: art = '0;  // Undefined codes render blank
        endcase
    end

    // Full bit reversal maps art position to row*5 + col
    always_comb begin
        for (int i = 0; i < 35; i++) begin
            glyph_bits[i] = art[34 - i];
        end
    end

endmodule : char_rom

`default_nettype wire

// File: vga_timing.sv
// 1024x768 VGA counters, sync and blank decode, frame interrupt flag
`timescale 1ns/1ps
`default_nettype none

`include "console_consts.svh"

module vga_timing
    import console_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       read_status_strobe,  // Host read of REG_VGA
    output pix_coord_t pix_x,
    output pix_coord_t pix_y,
    output logic       hsync,               // Active low
    output logic       vsync,               // Active low
    output logic       blank,
    output logic       frame_irq
);

    logic line_end;     // Last pixel clock of a line
    logic frame_end;    // Last line of a frame
    logic vsync_start;  // Next edge moves into the vsync lines

    assign line_end    = (pix_x == pix_coord_t'(`H_TOTAL - 1));
    assign frame_end   = (pix_y == pix_coord_t'(`V_TOTAL - 1));
    assign vsync_start = line_end && (pix_y == pix_coord_t'(`V_VISIBLE + `V_FRONT - 1));

    // Pixel counter, one step per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_x <= '0;
        end else if (line_end) begin
            pix_x <= '0;
        end else begin
            pix_x <= pix_x + 11'd1;
        end
    end

    // Line counter steps when the pixel counter wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_y <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                pix_y <= '0;
            end else begin
                pix_y <= pix_y + 11'd1;
            end
        end
    end

    // Sync pulses sit between front and back porch
    assign hsync = ~((pix_x >= pix_coord_t'(`H_VISIBLE + `H_FRONT)) &&
                     (pix_x <  pix_coord_t'(`H_VISIBLE + `H_FRONT + `H_SYNC)));
    assign vsync = ~((pix_y >= pix_coord_t'(`V_VISIBLE + `V_FRONT)) &&
                     (pix_y <  pix_coord_t'(`V_VISIBLE + `V_FRONT + `V_SYNC)));

    assign blank = (pix_x >= pix_coord_t'(`H_VISIBLE)) ||
                   (pix_y >= pix_coord_t'(`V_VISIBLE));

    // Sticky frame flag, set together with the vsync fall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_irq <= 1'b0;
        end else if (read_status_strobe) begin
            frame_irq <= 1'b0;  // Host read wins over a new frame
        end else if (vsync_start) begin
            frame_irq <= 1'b1;
        end
    end

    // Counter stays inside the line
    a_pix_x_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_x < pix_coord_t'(`H_TOTAL)
    ) else $error("pix_x reached H_TOTAL");

    // Interrupt only rises at a vsync falling edge
    a_irq_on_vsync: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(frame_irq) |-> $fell(vsync)
    ) else $error("frame_irq rose without vsync falling");

endmodule : vga_timing

`default_nettype wire

// File: console_pkg.sv
// Vector typedefs shared by the console blocks
`default_nettype none

package console_pkg;

    // 7-bit character code, ASCII subset
    typedef logic [6:0] char_code_t;

    // Colour packed as {B[1:0], G[1:0], R[1:0]}
    typedef logic [5:0] color_t;

    // Screen coordinate, wide enough for H_TOTAL
    typedef logic [10:0] pix_coord_t;

    // Index into the 30 entry text buffer
    typedef logic [4:0] buf_addr_t;

    // 5x7 bitmap, bit row*5 + col with row 0 on top and col 0 on the left
    typedef logic [34:0] glyph_t;

    // Peripheral bus address
    typedef logic [5:0] reg_addr_t;

endpackage : console_pkg

`default_nettype wire

// File: console_consts.svh
// Text geometry, register map, 1024x768 mode timing and reset colours
`ifndef CONSOLE_CONSTS_SVH
`define CONSOLE_CONSTS_SVH

// Text buffer geometry
`define NUM_ROWS          3
`define NUM_COLS          10
`define NUM_CHARS         (`NUM_ROWS * `NUM_COLS)  // 30 buffer entries

// Register map, text buffer sits at 0 to NUM_CHARS-1
`define REG_TEXT_COLOR    6'h30   // Bit 7 transparent, bits 5:0 colour
`define REG_BG_COLOR      6'h31
`define REG_VGA           6'h32   // Bit 1 vsync, bit 0 blank

// Horizontal timing in pixel clocks
`define H_VISIBLE         1024
`define H_FRONT           24
`define H_SYNC            136
`define H_BACK            160
`define H_TOTAL           (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)  // 1344

// Vertical timing in lines
`define V_VISIBLE         768
`define V_FRONT           3
`define V_SYNC            6
`define V_BACK            29
`define V_TOTAL           (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)  // 806

// Text window on screen
`define FRAME_XMIN        32
`define FRAME_XMAX        992
`define FRAME_YMIN        128
`define FRAME_YMAX        512

// Cell and glyph pixel size in screen pixels
`define CELL_W            96
`define CELL_H            128
`define GLYPH_SCALE       16

// Colours after reset, packed B G R
`define RESET_TEXT_COLOR  6'b001100
`define RESET_BG_COLOR    6'b010000

`endif
